// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP := tb_tag_cache
FILELIST := tb.f
BUILD_DIR := obj_dir
LOG := sim.log
PASS_MSG := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb.f ====
+incdir+verilog
verilog/tag_cache_pkg.sv
verilog/req_issue.sv
verilog/req_fifo.sv
verilog/tag_compare.sv
verilog/tag_cache_top.sv
verif/tb_clock_gen.sv
verif/tb_tag_cache.sv

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int half_period = 10,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#2;
		rst_n = 1'b1; // released off the edge like the rest of the stimulus
	end

endmodule

// ==== verif/tb_tag_cache.sv ====
`timescale 1ns/1ns

`include "tag_cache_settings.svh"

module tb_tag_cache;

	import tag_cache_pkg::*;

	localparam int table_rows = 16;
	localparam int cycle_limit = table_rows * 12 + 50;

	logic clk;
	logic rst_n;
	logic req_valid_i;
	logic req_ready_o;
	logic [`TC_ADDR_WIDTH-1:0] req_addr_i;
	logic [`TC_ID_WIDTH-1:0] req_id_i;
	logic req_write_i;
	logic arvalid_o;
	logic arready_i;
	logic [`TC_ADDR_WIDTH-1:0] araddr_o;
	logic rvalid_i;
	logic rready_o;
	logic [31:0] rdata_i;
	logic res_valid_o;
	logic res_ready_i;
	logic [`TC_ID_WIDTH-1:0] res_id_o;
	lookup_kind_t res_kind_o;
	logic [31:0] res_tag_word_o;

	logic [`TC_ADDR_WIDTH-1:0] tbl_addr [table_rows];
	logic [`TC_ID_WIDTH-1:0] tbl_id [table_rows];
	logic tbl_write [table_rows];
	logic [31:0] tbl_word [table_rows];
	lookup_kind_t tbl_kind [table_rows];

	logic hold_results; // forces res_ready low and arready high
	int accepted_count;
	int ar_count;
	int res_count;

	tb_clock_gen clock_gen_inst (
		.clk(clk),
		.rst_n(rst_n)
	);

	tag_cache_top tag_cache_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid_i(req_valid_i),
		.req_ready_o(req_ready_o),
		.req_addr_i(req_addr_i),
		.req_id_i(req_id_i),
		.req_write_i(req_write_i),
		.arvalid_o(arvalid_o),
		.arready_i(arready_i),
		.araddr_o(araddr_o),
		.rvalid_i(rvalid_i),
		.rready_o(rready_o),
		.rdata_i(rdata_i),
		.res_valid_o(res_valid_o),
		.res_ready_i(res_ready_i),
		.res_id_o(res_id_o),
		.res_kind_o(res_kind_o),
		.res_tag_word_o(res_tag_word_o)
	);

	// ****************************************
	// helpers
	// ****************************************

	task automatic report_mismatch(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopped at the first problem");
	endtask

	// one tag word per set, so the set index scales by the word size
	function automatic logic [31:0] tag_store_addr(input logic [31:0] addr);
		tag_store_addr = `TC_TAG_BASE + 32'(addr[`TC_OFFSET_WIDTH +: `TC_INDEX_WIDTH]) * 32'd4;
	endfunction

	task automatic fill_row(input int row, input logic [31:0] addr, input logic [3:0] id,
		input logic wr, input logic [31:0] word, input lookup_kind_t kind);
		tbl_addr[row] = addr;
		tbl_id[row] = id;
		tbl_write[row] = wr;
		tbl_word[row] = word;
		tbl_kind[row] = kind;
	endtask

	task automatic load_table();
		fill_row(0, 32'h1234_0040, 4'h5, 1'b0, 32'h8000_1234, read_hit);
		fill_row(1, 32'h1234_0080, 4'hC, 1'b0, 32'h0000_1234, read_miss); // valid bit clear
		fill_row(2, 32'hABCD_FFC0, 4'h0, 1'b1, 32'h8000_ABCD, write_hit); // last set
		fill_row(3, 32'hABCD_0004, 4'h9, 1'b1, 32'h8000_ABCC, write_miss);
		fill_row(4, 32'h0000_0000, 4'hE, 1'b0, 32'h8000_0000, read_hit);
		fill_row(5, 32'hFFFF_FFFF, 4'h3, 1'b0, 32'hFFFF_FFFF, read_hit); // spare bits ignored
		fill_row(6, 32'h5555_1234, 4'h7, 1'b1, 32'h7FFF_5555, write_miss);
		fill_row(7, 32'h5555_2000, 4'hA, 1'b1, 32'hC0DE_5555, write_hit);
		fill_row(8, 32'h0F0F_0100, 4'h1, 1'b0, 32'h8000_F0F0, read_miss);
		fill_row(9, 32'h0F0F_0140, 4'hF, 1'b1, 32'h8000_0F0F, write_hit);
		fill_row(10, 32'hDEAD_BEEF, 4'h6, 1'b0, 32'h8000_DEAD, read_hit);
		fill_row(11, 32'hDEAD_BEEF, 4'h2, 1'b1, 32'h0000_DEAD, write_miss);
		fill_row(12, 32'h8000_0400, 4'hB, 1'b0, 32'h8000_8001, read_miss);
		fill_row(13, 32'h7FFF_FFC0, 4'h4, 1'b1, 32'h8000_7FFF, write_hit);
		fill_row(14, 32'h3C3C_3C3C, 4'h8, 1'b0, 32'h4000_3C3C, read_miss); // bit 30 is not valid
		fill_row(15, 32'h2468_ACE0, 4'hD, 1'b1, 32'hFFFF_0000, write_miss);
	endtask

	task automatic send_request(input int row);
		logic taken;
		req_valid_i = 1'b1;
		req_addr_i = tbl_addr[row];
		req_id_i = tbl_id[row];
		req_write_i = tbl_write[row];
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = req_ready_o;
			@(posedge clk);
			#2;
		end
		accepted_count++;
		req_valid_i = 1'b0;
	endtask

	// ****************************************
	// DRAM responder and result checker
	// ****************************************

	initial begin : dram_model
		int pend_row [$];
		int pend_delay [$];
		logic r_fire;
		void'($urandom(32'h60dea2e5));
		rvalid_i = 1'b0;
		rdata_i = '0;
		arready_i = 1'b0;
		res_ready_i = 1'b0;
		ar_count = 0;
		forever begin
			@(negedge clk);
			r_fire = rvalid_i & rready_o;
			if (rst_n && arvalid_o && arready_i) begin
				assert (ar_count < table_rows) else report_problem("AR issued beyond the table");
				assert (araddr_o == tag_store_addr(tbl_addr[ar_count])) else report_mismatch(
					$sformatf("araddr %h for row %0d, expected %h", araddr_o, ar_count,
					tag_store_addr(tbl_addr[ar_count])));
				pend_row.push_back(ar_count);
				pend_delay.push_back($urandom % 4);
				ar_count++;
			end
			@(posedge clk);
			#2;
			if (r_fire) begin
				rvalid_i = 1'b0;
				void'(pend_row.pop_front());
				void'(pend_delay.pop_front());
			end
			if (!rvalid_i && pend_row.size() > 0) begin
				if (pend_delay[0] == 0) begin
					rvalid_i = 1'b1;
					rdata_i = tbl_word[pend_row[0]];
				end else begin
					pend_delay[0] = pend_delay[0] - 1;
				end
			end
			arready_i = hold_results ? 1'b1 : (($urandom % 4) != 0);
			res_ready_i = hold_results ? 1'b0 : (($urandom % 2) == 0); // ready of the result sink
		end
	end

	initial begin : result_check
		int row;
		res_count = 0;
		forever begin
			@(negedge clk);
			if (rst_n && res_valid_o && !res_ready_i) begin
				assert (!rready_o) else report_mismatch("rready_o high while the result is held");
			end
			if (rst_n && res_valid_o && res_ready_i) begin
				assert (res_count < table_rows) else report_problem("result seen after all rows");
				row = res_count;
				assert (res_id_o == tbl_id[row]) else report_mismatch(
					$sformatf("row %0d id %h, expected %h", row, res_id_o, tbl_id[row]));
				assert (res_kind_o == tbl_kind[row]) else report_mismatch($sformatf(
					"row %0d kind %s, expected %s", row, res_kind_o.name(), tbl_kind[row].name()));
				assert (res_tag_word_o == tbl_word[row]) else report_mismatch($sformatf(
					"row %0d tag word %h, expected %h", row, res_tag_word_o, tbl_word[row]));
				res_count++;
			end
		end
	end

	initial begin : watchdog
		int cycle_count;
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= cycle_limit) begin
				$display("Timeout after %0d cycles, %0d of %0d results seen", cycle_count,
					res_count, table_rows);
				$display("Simulation failed");
				$fatal(1, "run did not finish in time");
			end
		end
	end

	// ****************************************
	// main sequence
	// ****************************************

	initial begin : main_flow
		int start_count;
		req_valid_i = 1'b0;
		req_addr_i = '0;
		req_id_i = '0;
		req_write_i = 1'b0;
		hold_results = 1'b0;
		accepted_count = 0;
		load_table();
		@(posedge rst_n);
		@(negedge clk);
		assert (!arvalid_o && !res_valid_o && !rready_o && req_ready_o) else report_mismatch(
			"outputs not idle after reset");
		@(posedge clk);
		#2;
		for (int i = 0; i < 8; i++) send_request(i);
		fork
			for (int i = 8; i < table_rows; i++) send_request(i);
			begin
				#3;
				hold_results = 1'b1;
				start_count = accepted_count;
				repeat (20) @(posedge clk);
				#5;
				assert (accepted_count - start_count <= `TC_FIFO_DEPTH + 1) else report_mismatch(
					$sformatf("%0d requests taken while stalled", accepted_count - start_count));
				assert (!req_ready_o) else report_mismatch("req_ready_o still high while stalled");
				hold_results = 1'b0;
			end
		join
		wait (res_count == table_rows);
		repeat (10) @(posedge clk);
		assert (ar_count == table_rows) else report_mismatch(
			$sformatf("%0d AR transfers, expected %0d", ar_count, table_rows));
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== verilog/req_fifo.sv ====
`timescale 1ns/1ns

module req_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n,

	// write side
	input logic push_i,
	input payload_t push_data_i,

	// read side, head shown without a read request
	input logic pop_i,
	output payload_t head_o,
	output logic empty_o,
	output logic full_o
);

	localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cnt_w = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty_o = (count == '0);
	assign full_o = (count == cnt_w'(DEPTH));

	assign do_push = push_i & ~full_o;
	assign do_pop = pop_i & ~empty_o;

	// ****************************************
	// storage
	// ****************************************

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	assign head_o = mem[rd_ptr];

	// ****************************************
	// pointers and occupancy
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (do_push) begin
			// wrap by compare, DEPTH need not be a power of two
			wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither keep the level
			endcase
		end
	end

endmodule

// ==== verilog/req_issue.sv ====
`timescale 1ns/1ns

`include "tag_cache_settings.svh"

module req_issue (
	input logic clk,
	input logic rst_n,

	// client request channel
	input logic req_valid_i,
	output logic req_ready_o,
	input logic [`TC_ADDR_WIDTH-1:0] req_addr_i,
	input logic [`TC_ID_WIDTH-1:0] req_id_i,
	input logic req_write_i,

	// AR channel
	output logic arvalid_o,
	input logic arready_i,
	output logic [`TC_ADDR_WIDTH-1:0] araddr_o,

	// pending FIFO push side
	input logic fifo_full_i,
	output logic push_o,
	output tag_cache_pkg::pending_req_t push_data_o
);

	import tag_cache_pkg::*;

	logic [tag_width_p-1:0] req_tag;
	logic [`TC_INDEX_WIDTH-1:0] req_index;
	logic [`TC_ADDR_WIDTH-1:0] tag_addr;
	logic accept;
	logic ar_leaving;
	logic arvalid_q;
	logic [`TC_ADDR_WIDTH-1:0] araddr_q;

	// ****************************************
	// address split
	// ****************************************

	assign req_tag = req_addr_i[`TC_ADDR_WIDTH-1 -: tag_width_p];
	assign req_index = req_addr_i[`TC_OFFSET_WIDTH +: `TC_INDEX_WIDTH];

	// index scaled by four bytes into the tag store
	assign tag_addr = `TC_TAG_BASE
		+ {{(`TC_ADDR_WIDTH - `TC_INDEX_WIDTH - 2){1'b0}}, req_index, 2'b00};

	// ****************************************
	// handshake and AR register
	// ****************************************

	assign ar_leaving = arvalid_q & arready_i;
	assign req_ready_o = ~fifo_full_i & (~arvalid_q | arready_i); // slot frees as AR leaves
	assign accept = req_valid_i & req_ready_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			arvalid_q <= 1'b0;
		end else if (accept) begin
			arvalid_q <= 1'b1;
		end else if (ar_leaving) begin
			arvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			araddr_q <= tag_addr; // held until arready
		end
	end

	assign arvalid_o = arvalid_q;
	assign araddr_o = araddr_q;

	// the lookup is recorded in the same cycle it is accepted
	assign push_o = accept;
	assign push_data_o.id = req_id_i;
	assign push_data_o.tag = req_tag;
	assign push_data_o.index = req_index;
	assign push_data_o.is_write = req_write_i;

endmodule

// ==== verilog/tag_cache_pkg.sv ====
`include "tag_cache_settings.svh"

package tag_cache_pkg;

	// ****************************************
	// derived widths
	// ****************************************

	localparam int tag_width_p = `TC_ADDR_WIDTH - `TC_INDEX_WIDTH - `TC_OFFSET_WIDTH;
	localparam int tag_word_width_p = 32; // one R beat
	localparam int tag_rsvd_width_p = tag_word_width_p - 1 - tag_width_p;

	// word kept per set in the DRAM tag store
	typedef struct packed {
		logic valid; // line holds data
		logic [tag_rsvd_width_p-1:0] rsvd; // spare bits, ignored on compare
		logic [tag_width_p-1:0] tag;
	} tag_word_t;

	// ****************************************
	// pending lookup record
	// ****************************************

	typedef struct packed {
		logic [`TC_ID_WIDTH-1:0] id;
		logic [tag_width_p-1:0] tag; // tag of the request, compared later
		logic [`TC_INDEX_WIDTH-1:0] index;
		logic is_write;
	} pending_req_t;

	// outcome reported on the result channel
	typedef enum logic [1:0] {
		read_hit = 2'd0,
		read_miss = 2'd1,
		write_hit = 2'd2,
		write_miss = 2'd3
	} lookup_kind_t;

endpackage

// ==== verilog/tag_cache_settings.svh ====
`ifndef TAG_CACHE_SETTINGS_SVH
`define TAG_CACHE_SETTINGS_SVH

// ****************************************
// client request fields
// ****************************************

`define TC_ADDR_WIDTH 32 // byte address from the client
`define TC_ID_WIDTH 4 // request id returned with the result

// ****************************************
// cache geometry
// ****************************************

`define TC_INDEX_WIDTH 10 // 1024 sets
`define TC_OFFSET_WIDTH 6 // 64 byte lines

// tag words sit one per set, four bytes apart
`define TC_TAG_BASE 32'h8000_0000

// ****************************************
// lookup pipeline
// ****************************************

`define TC_FIFO_DEPTH 4 // lookups that may wait for their R beat

`endif

// ==== verilog/tag_cache_top.sv ====
`timescale 1ns/1ns

`include "tag_cache_settings.svh"

module tag_cache_top (
	input logic clk,
	input logic rst_n,

	// client request channel
	input logic req_valid_i,
	output logic req_ready_o,
	input logic [`TC_ADDR_WIDTH-1:0] req_addr_i,
	input logic [`TC_ID_WIDTH-1:0] req_id_i,
	input logic req_write_i,

	// AR channel to DRAM
	output logic arvalid_o,
	input logic arready_i,
	output logic [`TC_ADDR_WIDTH-1:0] araddr_o,

	// R channel from DRAM, single beats in order
	input logic rvalid_i,
	output logic rready_o,
	input tag_cache_pkg::tag_word_t rdata_i,

	// result channel
	output logic res_valid_o,
	input logic res_ready_i,
	output logic [`TC_ID_WIDTH-1:0] res_id_o,
	output tag_cache_pkg::lookup_kind_t res_kind_o,
	output tag_cache_pkg::tag_word_t res_tag_word_o
);

	import tag_cache_pkg::*;

	// ****************************************
	// internal links
	// ****************************************

	logic push;
	pending_req_t push_data;
	logic fifo_full;
	pending_req_t fifo_head;
	logic fifo_empty;
	logic pop;

	req_issue req_issue_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid_i(req_valid_i),
		.req_ready_o(req_ready_o),
		.req_addr_i(req_addr_i),
		.req_id_i(req_id_i),
		.req_write_i(req_write_i),
		.arvalid_o(arvalid_o),
		.arready_i(arready_i),
		.araddr_o(araddr_o),
		.fifo_full_i(fifo_full),
		.push_o(push),
		.push_data_o(push_data)
	);

	// one entry per AR still waiting for its tag word
	req_fifo #(
		.payload_t(pending_req_t),
		.DEPTH(`TC_FIFO_DEPTH)
	) req_fifo_inst (
		.clk(clk),
		.rst_n(rst_n),
		.push_i(push),
		.push_data_i(push_data),
		.pop_i(pop),
		.head_o(fifo_head),
		.empty_o(fifo_empty),
		.full_o(fifo_full)
	);

	tag_compare tag_compare_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rvalid_i(rvalid_i),
		.rready_o(rready_o),
		.rdata_i(rdata_i),
		.empty_i(fifo_empty),
		.head_i(fifo_head),
		.pop_o(pop),
		.res_valid_o(res_valid_o),
		.res_ready_i(res_ready_i),
		.res_id_o(res_id_o),
		.res_kind_o(res_kind_o),
		.res_tag_word_o(res_tag_word_o)
	);

endmodule

// ==== verilog/tag_compare.sv ====
`timescale 1ns/1ns

`include "tag_cache_settings.svh"

module tag_compare (
	input logic clk,
	input logic rst_n,

	// R channel
	input logic rvalid_i,
	output logic rready_o,
	input tag_cache_pkg::tag_word_t rdata_i,

	// pending FIFO read side
	input logic empty_i,
	input tag_cache_pkg::pending_req_t head_i,
	output logic pop_o,

	// result channel
	output logic res_valid_o,
	input logic res_ready_i,
	output logic [`TC_ID_WIDTH-1:0] res_id_o,
	output tag_cache_pkg::lookup_kind_t res_kind_o,
	output tag_cache_pkg::tag_word_t res_tag_word_o
);

	import tag_cache_pkg::*;

	logic res_free;
	logic r_fire;
	logic hit;
	lookup_kind_t kind_next;

	logic res_valid_q;
	logic [`TC_ID_WIDTH-1:0] res_id_q;
	lookup_kind_t res_kind_q;
	tag_word_t res_tag_word_q;

	// ****************************************
	// R acceptance
	// ****************************************

	// result slot is free when empty or being taken this cycle
	assign res_free = ~res_valid_q | res_ready_i;
	assign rready_o = ~empty_i & res_free;
	assign r_fire = rvalid_i & rready_o;
	assign pop_o = r_fire; // responses are in order, so the head owns this beat

	// ****************************************
	// classification
	// ****************************************

	assign hit = rdata_i.valid & (rdata_i.tag == head_i.tag);

	always_comb begin
		case ({head_i.is_write, hit})
			2'b01: kind_next = read_hit;
			2'b00: kind_next = read_miss;
			2'b11: kind_next = write_hit;
			default: kind_next = write_miss;
		endcase
	end

	// ****************************************
	// result register
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid_q <= 1'b0;
		end else if (r_fire) begin
			res_valid_q <= 1'b1;
		end else if (res_ready_i) begin
			res_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (r_fire) begin
			res_id_q <= head_i.id;
			res_kind_q <= kind_next;
			res_tag_word_q <= rdata_i; // raw word goes back for refill decisions
		end
	end

	assign res_valid_o = res_valid_q;
	assign res_id_o = res_id_q;
	assign res_kind_o = res_kind_q;
	assign res_tag_word_o = res_tag_word_q;

endmodule
